/* common/eightbit_config.svh */
`ifndef EIGHTBIT_CONFIG_SVH
`define EIGHTBIT_CONFIG_SVH

// data path and memory address width.
`define DATA_W 8

`define NUM_REGS 16
`define QUEUE_DEPTH 2

// opcode field values, bits 15:12 of an instruction.
`define OP_JMP  4'd0
`define OP_LOD  4'd1
`define OP_STR  4'd2
`define OP_ADD  4'd3
`define OP_ADDI 4'd4
`define OP_LODI 4'd5
`define OP_NAND 4'd6
`define OP_JEQZ 4'd7

`endif

/* common/eightbit_pkg.sv */
`include "eightbit_config.svh"

package eightbit_pkg;

    typedef logic [`DATA_W-1:0] byte_t;          // data value or memory address.
    typedef logic [2*`DATA_W-1:0] inst_t;        // high byte at pc, low byte at pc+1.
    typedef logic [3:0] opcode_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

    // fetch reads two bytes per instruction.
    typedef enum logic [1:0] {
        FETCH_IDLE,
        HIGH_BYTE,
        LOW_BYTE
    } fetch_state_t;

    typedef enum logic [2:0] {
        EXEC_IDLE,
        ISSUE,
        EXECUTE,
        MEM_WAIT,
        WRITEBACK
    } exec_state_t;

endpackage

/* design/bus_arbiter.sv */
module bus_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetch_req,
    input  eightbit_pkg::byte_t fetch_addr,
    input  logic                exec_req,
    input  logic                exec_we,
    input  eightbit_pkg::byte_t exec_addr,
    input  eightbit_pkg::byte_t exec_wdata,
    input  logic                mem_ready,
    output logic                fetch_ready,
    output logic                exec_mem_ready,
    output logic                mem_req,
    output logic                mem_we,
    output eightbit_pkg::byte_t mem_addr,
    output eightbit_pkg::byte_t mem_wdata
);
    logic busy_q;
    logic fetch_lock_q;
    logic sel_fetch;

    // once a read is on the bus the owner is kept until ready.
    assign sel_fetch = busy_q ? fetch_lock_q : (fetch_req && !exec_req);

    assign mem_req        = sel_fetch ? fetch_req : exec_req;
    assign mem_we         = sel_fetch ? 1'b0 : exec_we;
    assign mem_addr       = sel_fetch ? fetch_addr : exec_addr;
    assign mem_wdata      = sel_fetch ? '0 : exec_wdata;
    assign fetch_ready    = mem_req && mem_ready && sel_fetch;
    assign exec_mem_ready = mem_req && mem_ready && !sel_fetch;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q       <= 1'b0;
            fetch_lock_q <= 1'b0;
        end else if (mem_req && mem_ready) begin
            busy_q       <= 1'b0;
            fetch_lock_q <= 1'b0;
        end else if (mem_req) begin
            busy_q       <= 1'b1;
            fetch_lock_q <= sel_fetch;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(fetch_ready && exec_mem_ready))
        else $error("ready steered to both masters");
    // both masters must hold their request fields for the bus rule to hold.
    assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ready |=> mem_req && $stable(mem_addr) && $stable(mem_we) &&
                                   $stable(mem_wdata))
        else $error("bus request changed before ready");

endmodule

/* design/decode.sv */
`include "eightbit_config.svh"

module decode (
    input  eightbit_pkg::inst_t    inst,
    output eightbit_pkg::opcode_t  op,
    output eightbit_pkg::reg_idx_t dest,
    output eightbit_pkg::reg_idx_t rd_a,
    output eightbit_pkg::reg_idx_t rd_b,
    output eightbit_pkg::byte_t    imm
);
    import eightbit_pkg::*;

    reg_idx_t r1;
    reg_idx_t r2;
    logic     use_r0;

    assign op   = inst[15:12];
    assign dest = inst[11:8];
    assign r1   = inst[7:4];
    assign r2   = inst[3:0];
    assign imm  = inst[7:0];

    // these read their own destination field as an operand.
    assign use_r0 = (op == `OP_STR) || (op == `OP_JEQZ) || (op == `OP_ADDI);

    always_comb begin
        if (use_r0) begin
            rd_a = dest;
            rd_b = r1;
        end else begin
            rd_a = r1;
            rd_b = r2;
        end
    end

endmodule

/* design/eightbit.sv */
module eightbit (
    input  logic                clk,
    input  logic                rst,
    input  logic                mem_ready,
    input  eightbit_pkg::byte_t mem_rdata,
    output logic                mem_req,
    output logic                mem_we,
    output eightbit_pkg::byte_t mem_addr,
    output eightbit_pkg::byte_t mem_wdata
);
    import eightbit_pkg::*;

    logic  fetch_req;
    byte_t fetch_addr;
    logic  fetch_ready;
    logic  push;
    inst_t push_inst;
    byte_t push_pc;
    logic  full;
    logic  empty;
    inst_t head_inst;
    byte_t head_pc;
    logic  pop;
    logic  flush;
    byte_t flush_target;
    logic  exec_req;
    logic  exec_we;
    byte_t exec_addr;
    byte_t exec_wdata;
    logic  exec_mem_ready;

    fetch_unit fetch0 (
        .clk          (clk),
        .rst          (rst),
        .full         (full),
        .flush        (flush),
        .flush_target (flush_target),
        .fetch_ready  (fetch_ready),
        .rdata        (mem_rdata),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .push         (push),
        .push_inst    (push_inst),
        .push_pc      (push_pc)
    );

    inst_queue queue0 (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .push      (push),
        .push_inst (push_inst),
        .push_pc   (push_pc),
        .pop       (pop),
        .head_inst (head_inst),
        .head_pc   (head_pc),
        .full      (full),
        .empty     (empty)
    );

    exec_unit exec0 (
        .clk            (clk),
        .rst            (rst),
        .empty          (empty),
        .head_inst      (head_inst),
        .head_pc        (head_pc),
        .exec_mem_ready (exec_mem_ready),
        .rdata          (mem_rdata),
        .pop            (pop),
        .flush          (flush),
        .flush_target   (flush_target),
        .exec_req       (exec_req),
        .exec_we        (exec_we),
        .exec_addr      (exec_addr),
        .exec_wdata     (exec_wdata)
    );

    bus_arbiter arb0 (
        .clk            (clk),
        .rst            (rst),
        .fetch_req      (fetch_req),
        .fetch_addr     (fetch_addr),
        .exec_req       (exec_req),
        .exec_we        (exec_we),
        .exec_addr      (exec_addr),
        .exec_wdata     (exec_wdata),
        .mem_ready      (mem_ready),
        .fetch_ready    (fetch_ready),
        .exec_mem_ready (exec_mem_ready),
        .mem_req        (mem_req),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata)
    );

endmodule

/* design/exec_unit.sv */
`include "eightbit_config.svh"

module exec_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                empty,
    input  eightbit_pkg::inst_t head_inst,
    input  eightbit_pkg::byte_t head_pc,
    input  logic                exec_mem_ready,
    input  eightbit_pkg::byte_t rdata,
    output logic                pop,
    output logic                flush,
    output eightbit_pkg::byte_t flush_target,
    output logic                exec_req,
    output logic                exec_we,
    output eightbit_pkg::byte_t exec_addr,
    output eightbit_pkg::byte_t exec_wdata
);
    import eightbit_pkg::*;

    exec_state_t state;
    opcode_t     dec_op;
    opcode_t     op_q;
    reg_idx_t    dec_dest;
    reg_idx_t    dec_rd_a;
    reg_idx_t    dec_rd_b;
    reg_idx_t    dest_q;
    byte_t       dec_imm;
    byte_t       imm_q;
    byte_t       rdata_a;
    byte_t       rdata_b;
    byte_t       a_q;
    byte_t       b_q;
    byte_t       alu_result;
    byte_t       wb_data_q;
    byte_t       next_pc_q;
    logic        reg_we;

    decode dec0 (
        .inst (head_inst),
        .op   (dec_op),
        .dest (dec_dest),
        .rd_a (dec_rd_a),
        .rd_b (dec_rd_b),
        .imm  (dec_imm)
    );

    reg_file regs0 (
        .clk     (clk),
        .rst     (rst),
        .rd_a    (dec_rd_a),
        .rd_b    (dec_rd_b),
        .we      (reg_we),
        .wr_idx  (dest_q),
        .wr_data (wb_data_q),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    assign pop          = (state == ISSUE);
    assign exec_req     = (state == MEM_WAIT);
    assign reg_we       = (state == WRITEBACK);
    assign flush_target = imm_q;
    assign flush = (state == EXECUTE) &&
                   ((op_q == `OP_JMP) || ((op_q == `OP_JEQZ) && (a_q == '0)));

    always_comb begin
        case (op_q)
            `OP_ADD:  alu_result = a_q + b_q;
            `OP_ADDI: alu_result = a_q + imm_q;
            `OP_NAND: alu_result = ~(a_q & b_q);
            default:  alu_result = imm_q;                // lodi.
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= EXEC_IDLE;
            exec_we    <= 1'b0;
            exec_addr  <= '0;
            exec_wdata <= '0;
            next_pc_q  <= '0;
        end else begin
            case (state)
                EXEC_IDLE: begin
                    if (!empty) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    next_pc_q <= head_pc + 8'd2;
                    state     <= EXECUTE;
                end
                EXECUTE: begin
                    case (op_q)
                        `OP_LOD, `OP_STR: begin
                            // lod reads port a as the address, str reads port b.
                            exec_we    <= (op_q == `OP_STR);
                            exec_addr  <= (op_q == `OP_STR) ? b_q : a_q;
                            exec_wdata <= a_q;
                            state      <= MEM_WAIT;
                        end
                        `OP_ADD, `OP_ADDI, `OP_LODI, `OP_NAND: state <= WRITEBACK;
                        default: begin
                            if (flush) begin
                                next_pc_q <= imm_q;
                            end
                            state <= EXEC_IDLE;                  // the queue is clearing now.
                        end
                    endcase
                end
                MEM_WAIT: begin
                    if (exec_mem_ready) begin
                        state <= exec_we ? EXEC_IDLE : WRITEBACK;
                    end
                end
                WRITEBACK: state <= empty ? EXEC_IDLE : ISSUE;
                default:   state <= EXEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ISSUE) begin
            op_q   <= dec_op;
            dest_q <= dec_dest;
            imm_q  <= dec_imm;
            a_q    <= rdata_a;
            b_q    <= rdata_b;
        end
        if (state == EXECUTE) begin
            wb_data_q <= alu_result;
        end else if ((state == MEM_WAIT) && exec_mem_ready) begin
            wb_data_q <= rdata;
        end
    end

    assert property (@(posedge clk) disable iff (rst) exec_req && !exec_mem_ready |=> exec_req)
        else $error("execute dropped its bus request before ready");
    // fetch, flush and queue together must deliver instructions in program order.
    assert property (@(posedge clk) disable iff (rst) pop |-> (head_pc == next_pc_q))
        else $error("issued instruction is out of program order");

endmodule

/* design/reg_file.sv */
`include "eightbit_config.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  eightbit_pkg::reg_idx_t rd_a,
    input  eightbit_pkg::reg_idx_t rd_b,
    input  logic                   we,
    input  eightbit_pkg::reg_idx_t wr_idx,
    input  eightbit_pkg::byte_t    wr_data,
    output eightbit_pkg::byte_t    rdata_a,
    output eightbit_pkg::byte_t    rdata_b
);
    import eightbit_pkg::*;

    byte_t regs [`NUM_REGS];

    assign rdata_a = regs[rd_a];
    assign rdata_b = regs[rd_b];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

/* eightbit.f */
+incdir+common
common/eightbit_pkg.sv
fetch/fetch_unit.sv
fetch/inst_queue.sv
design/decode.sv
design/reg_file.sv
design/exec_unit.sv
design/bus_arbiter.sv
design/eightbit.sv
sim/clock_gen.sv
sim/eightbit_tb.sv

/* fetch/fetch_unit.sv */
module fetch_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                full,
    input  logic                flush,
    input  eightbit_pkg::byte_t flush_target,
    input  logic                fetch_ready,
    input  eightbit_pkg::byte_t rdata,
    output logic                fetch_req,
    output eightbit_pkg::byte_t fetch_addr,
    output logic                push,
    output eightbit_pkg::inst_t push_inst,
    output eightbit_pkg::byte_t push_pc
);
    import eightbit_pkg::*;

    fetch_state_t state;
    byte_t        pc;
    byte_t        addr_q;
    byte_t        high_q;
    logic         abort_q;
    logic         take_high;
    logic         take_low;

    assign fetch_req  = (state != FETCH_IDLE);
    assign fetch_addr = addr_q;                          // held for the whole bus read.
    assign take_high  = (state == HIGH_BYTE) && fetch_ready;
    assign take_low   = (state == LOW_BYTE) && fetch_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= FETCH_IDLE;
            pc      <= '0;
            addr_q  <= '0;
            abort_q <= 1'b0;
            push    <= 1'b0;
        end else begin
            push <= 1'b0;
            if (flush) begin
                pc <= flush_target;
            end
            case (state)
                FETCH_IDLE: begin
                    // a push in flight is not yet counted by the queue.
                    if (!flush && !full && !push) begin
                        addr_q <= pc;
                        state  <= HIGH_BYTE;
                    end
                end
                HIGH_BYTE: begin
                    if (fetch_ready) begin
                        if (flush || abort_q) begin
                            abort_q <= 1'b0;
                            state   <= FETCH_IDLE;
                        end else begin
                            addr_q <= addr_q + 8'd1;
                            state  <= LOW_BYTE;
                        end
                    end else if (flush) begin
                        abort_q <= 1'b1;                 // let the read finish, then drop it.
                    end
                end
                LOW_BYTE: begin
                    if (fetch_ready) begin
                        abort_q <= 1'b0;
                        state   <= FETCH_IDLE;
                        if (!flush && !abort_q) begin
                            push <= 1'b1;
                            pc   <= pc + 8'd2;
                        end
                    end else if (flush) begin
                        abort_q <= 1'b1;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_high) begin
            high_q <= rdata;
        end
        if (take_low) begin
            push_inst <= {high_q, rdata};
            push_pc   <= pc;
        end
    end

    // relies on the queue count and the hold on a pending push.
    assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("fetch pushed into a full queue");

endmodule

/* fetch/inst_queue.sv */
`include "eightbit_config.svh"

module inst_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                push,
    input  eightbit_pkg::inst_t push_inst,
    input  eightbit_pkg::byte_t push_pc,
    input  logic                pop,
    output eightbit_pkg::inst_t head_inst,
    output eightbit_pkg::byte_t head_pc,
    output logic                full,
    output logic                empty
);
    import eightbit_pkg::*;

    localparam int DEPTH = `QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    inst_t          inst_mem [DEPTH];
    byte_t          pc_mem [DEPTH];
    ptr_t           wr_ptr;
    ptr_t           rd_ptr;
    logic [PTR_W:0] count;
    logic           do_push;
    logic           do_pop;

    function automatic ptr_t next_ptr(input ptr_t p);
        return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full      = (count == (PTR_W + 1)'(DEPTH));
    assign empty     = (count == '0);
    assign do_push   = push && !full;
    assign do_pop    = pop && !empty;
    assign head_inst = inst_mem[rd_ptr];
    assign head_pc   = pc_mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;                                // a push in the same cycle is dropped.
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !flush) begin
            inst_mem[wr_ptr] <= push_inst;
            pc_mem[wr_ptr]   <= push_pc;
        end
    end

    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("pop from an empty queue");
    assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("push into a full queue");

endmodule

/* sim/clock_gen.sv */
module clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;                                     // released just after the second edge.
    end

    always #10 clk = ~clk;                              // period of 20.

endmodule

/* sim/eightbit_tb.sv */
`include "eightbit_config.svh"

module eightbit_tb;
    import eightbit_pkg::*;

    localparam int RUN_TIMEOUT = 20000;

    logic  clk;
    logic  rst;
    logic  test_rst;
    logic  dut_rst;
    logic  mem_req;
    logic  mem_we;
    byte_t mem_addr;
    byte_t mem_wdata;
    logic  mem_ready;
    byte_t mem_rdata;

    byte_t image [256];
    byte_t mem [256];
    byte_t model_mem [256];
    int    lat_tab [256];
    byte_t lat_idx;
    inst_t prog [$];
    byte_t exp_addr [$];
    byte_t exp_data [$];
    byte_t st_addr [$];
    byte_t st_data [$];
    byte_t req_addr [$];
    logic  req_we [$];
    logic  marker_seen;
    logic  pending;
    int    delay;
    byte_t hold_addr;
    logic  hold_we;
    byte_t hold_wdata;
    int    seed;
    int    errors;
    int    tests_run;
    int    tests_failed;
    logic  timed_out;

    clock_gen clk_gen0 (
        .clk (clk),
        .rst (rst)
    );

    assign dut_rst = rst || test_rst;                   // the testbench restarts the core per program.

    eightbit dut0 (
        .clk       (clk),
        .rst       (dut_rst),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    task automatic report_error(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        errors++;
    endtask

    // memory with a random wait of 0 to 3 cycles before its one-cycle ready.
    always begin
        @(posedge clk);
        #1;
        mem_ready = 1'b0;
        if (dut_rst) begin
            pending = 1'b0;
        end else if (mem_req) begin
            if (!pending) begin
                pending    = 1'b1;
                hold_addr  = mem_addr;
                hold_we    = mem_we;
                hold_wdata = mem_wdata;
                delay      = lat_tab[lat_idx];
                lat_idx    = lat_idx + 8'd1;
                if (req_addr.size() < 4) begin
                    req_addr.push_back(mem_addr);
                    req_we.push_back(mem_we);
                end
            end else begin
                assert (mem_addr == hold_addr && mem_we == hold_we &&
                        (!hold_we || mem_wdata == hold_wdata))
                    else report_error($sformatf("request at 0x%02h changed before mem_ready",
                                                hold_addr));
            end
            if (delay == 0) begin
                mem_ready = 1'b1;
                pending   = 1'b0;
                if (hold_we) begin
                    mem[hold_addr] = hold_wdata;
                    st_addr.push_back(hold_addr);
                    st_data.push_back(hold_wdata);
                    if (hold_addr == 8'hff) begin
                        marker_seen = 1'b1;
                    end
                end else begin
                    mem_rdata = mem[hold_addr];
                end
            end else begin
                delay--;
            end
        end else begin
            assert (!pending) else report_error("mem_req dropped before mem_ready");
            pending = 1'b0;
        end
    end

    function automatic inst_t pack_regs(input opcode_t op, input reg_idx_t a,
                                        input reg_idx_t b, input reg_idx_t c);
        return {op, a, b, c};
    endfunction

    function automatic inst_t pack_imm(input opcode_t op, input reg_idx_t a, input byte_t imm);
        return {op, a, imm};
    endfunction

    function automatic reg_idx_t any_reg();
        return reg_idx_t'($urandom % 16);
    endfunction

    // r15 is kept as the store pointer.
    function automatic reg_idx_t low_reg();
        return reg_idx_t'($urandom % 15);
    endfunction

    function automatic byte_t data_ptr();
        return byte_t'(8'h80 + $urandom % 127);         // 0x80 to 0xfe, never the marker.
    endfunction

    function automatic inst_t alu_inst();
        case ($urandom % 4)
            0:       return pack_regs(`OP_ADD, low_reg(), any_reg(), any_reg());
            1:       return pack_imm(`OP_ADDI, low_reg(), byte_t'($urandom));
            2:       return pack_imm(`OP_LODI, low_reg(), ($urandom % 4 == 0) ? 8'h00 :
                                     byte_t'($urandom));
            default: return pack_regs(`OP_NAND, low_reg(), any_reg(), any_reg());
        endcase
    endfunction

    function automatic inst_t mem_inst();
        case ($urandom % 3)
            0:       return pack_regs(`OP_LOD, low_reg(),
                                      ($urandom % 2) ? 4'd15 : any_reg(), any_reg());
            1:       return pack_regs(`OP_STR, any_reg(), 4'd15, any_reg());
            default: return pack_imm(`OP_LODI, 4'd15, data_ptr());
        endcase
    endfunction

    // forward only, so every program reaches its epilogue.
    function automatic inst_t branch_inst(input int idx, input int body_len);
        int    span;
        byte_t target;
        span = 1 + $urandom % 3;
        if (idx + span > body_len) begin
            span = body_len - idx;
        end
        target = byte_t'(2 * (idx + span));
        if ($urandom % 2) begin
            return pack_imm(`OP_JMP, 4'd0, target);
        end
        return pack_imm(`OP_JEQZ, any_reg(), target);
    endfunction

    task automatic build_program(input int kind, input int body_len);
        int pick;
        prog.delete();
        if (kind > 0) begin
            prog.push_back(pack_imm(`OP_LODI, 4'd15, data_ptr()));
        end
        while (prog.size() < body_len) begin
            pick = $urandom % 10;
            if (kind >= 2 && pick < 2) begin
                prog.push_back(branch_inst(prog.size(), body_len));
            end else if (kind == 3 && pick == 2) begin
                prog.push_back(pack_regs(opcode_t'(8 + $urandom % 8), any_reg(), any_reg(),
                                         any_reg()));
            end else if (kind >= 1 && pick < 6) begin
                prog.push_back(mem_inst());
            end else begin
                prog.push_back(alu_inst());
            end
        end
        for (int r = 0; r < 15; r++) begin
            prog.push_back(pack_imm(`OP_LODI, 4'd15, byte_t'(8'h80 + r)));
            prog.push_back(pack_regs(`OP_STR, reg_idx_t'(r), 4'd15, 4'd0));
        end
        prog.push_back(pack_imm(`OP_LODI, 4'd15, 8'hff));
        prog.push_back(pack_regs(`OP_STR, 4'd0, 4'd15, 4'd0));
        prog.push_back(pack_imm(`OP_JMP, 4'd0, byte_t'(2 * prog.size())));
        for (int a = 0; a < 256; a++) begin
            image[a] = (a < 8'h80) ? 8'h00 : byte_t'($urandom);
        end
        foreach (prog[i]) begin
            image[2 * i]     = prog[i][15:8];
            image[2 * i + 1] = prog[i][7:0];
        end
    endtask

    // instruction set model, runs the program to its jump to itself.
    task automatic run_model();
        byte_t regs [16];
        byte_t pc;
        byte_t next_pc;
        inst_t w;
        int    steps;
        logic  done;
        model_mem = image;
        exp_addr.delete();
        exp_data.delete();
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            w       = {model_mem[pc], model_mem[pc + 8'd1]};
            next_pc = pc + 8'd2;
            case (w[15:12])
                `OP_JMP: begin
                    if (w[7:0] == pc) begin
                        done = 1'b1;
                    end else begin
                        next_pc = w[7:0];
                    end
                end
                `OP_JEQZ: begin
                    if (regs[w[11:8]] == 8'h00) begin
                        next_pc = w[7:0];
                    end
                end
                `OP_LOD:  regs[w[11:8]] = model_mem[regs[w[7:4]]];
                `OP_STR: begin
                    model_mem[regs[w[7:4]]] = regs[w[11:8]];
                    exp_addr.push_back(regs[w[7:4]]);
                    exp_data.push_back(regs[w[11:8]]);
                end
                `OP_ADD:  regs[w[11:8]] = regs[w[7:4]] + regs[w[3:0]];
                `OP_ADDI: regs[w[11:8]] = regs[w[11:8]] + w[7:0];
                `OP_LODI: regs[w[11:8]] = w[7:0];
                `OP_NAND: regs[w[11:8]] = ~(regs[w[7:4]] & regs[w[3:0]]);
                default:  ;
            endcase
            pc = next_pc;
            steps++;
        end
        assert (done) else report_error("reference model never reached its final jump");
    endtask

    task automatic restart_dut();
        @(posedge clk);
        #1;
        test_rst = 1'b1;
        @(posedge clk);
        #1;
        mem = image;
        st_addr.delete();
        st_data.delete();
        req_addr.delete();
        req_we.delete();
        marker_seen = 1'b0;
        @(posedge clk);
        #1;
        test_rst = 1'b0;
    endtask

    task automatic wait_marker(input string name);
        int cycles;
        cycles = 0;
        while (!marker_seen && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!marker_seen) begin
            timed_out = 1'b1;
            $display("timeout: test %s never stored its end marker within %0d cycles",
                     name, RUN_TIMEOUT);
        end
    endtask

    task automatic compare_stores(input string name);
        int n;
        assert (st_addr.size() == exp_addr.size())
            else report_error($sformatf("%s: %0d stores seen, %0d expected", name,
                                        st_addr.size(), exp_addr.size()));
        n = (st_addr.size() < exp_addr.size()) ? st_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            assert (st_addr[i] == exp_addr[i] && st_data[i] == exp_data[i])
                else report_error($sformatf("%s store %0d: got %02h:%02h, expected %02h:%02h",
                                            name, i, st_addr[i], st_data[i],
                                            exp_addr[i], exp_data[i]));
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors != start_errors || timed_out) begin
            tests_failed++;
            $display("test %s: error, %0d failed checks", name, errors - start_errors);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic reset_test();
        int cycles;
        int start_errors;
        start_errors = errors;
        build_program(0, 8);
        run_model();
        mem = image;
        @(posedge clk);
        cycles = 0;
        while (dut_rst && cycles < 10) begin
            @(negedge clk);
            assert (!mem_req && !mem_we)
                else report_error("mem_req or mem_we high during or right after reset");
            cycles++;
        end
        cycles = 0;
        while (req_addr.size() < 2 && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (req_addr.size() < 2) begin
            timed_out = 1'b1;
            $display("timeout: the core made fewer than two bus requests after reset");
        end else begin
            assert (req_addr[0] == 8'h00 && !req_we[0])
                else report_error($sformatf("first request 0x%02h, expected a read of 0x00",
                                            req_addr[0]));
            assert (req_addr[1] == 8'h01 && !req_we[1])
                else report_error($sformatf("second request 0x%02h, expected a read of 0x01",
                                            req_addr[1]));
        end
        if (!timed_out) begin
            wait_marker("reset_fetch");
        end
        if (!timed_out) begin
            compare_stores("reset_fetch");
        end
        finish_test("reset_fetch", start_errors);
    endtask

    task automatic run_test(input string name, input int kind, input int runs,
                            input int min_len);
        int start_errors;
        int body_len;
        start_errors = errors;
        for (int n = 0; n < runs && !timed_out; n++) begin
            body_len = min_len + $urandom % (32 - min_len);   // body plus epilogue fit 0x00-0x7f.
            build_program(kind, body_len);
            run_model();
            restart_dut();
            wait_marker(name);
            if (!timed_out) begin
                compare_stores(name);
            end
        end
        finish_test(name, start_errors);
    endtask

    initial begin
        seed = 31;
        void'($urandom(seed));
        test_rst     = 1'b0;
        mem_ready    = 1'b0;
        mem_rdata    = '0;
        pending      = 1'b0;
        marker_seen  = 1'b0;
        lat_idx      = '0;
        delay        = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        foreach (lat_tab[i]) begin
            lat_tab[i] = $urandom % 4;
        end
        reset_test();
        if (!timed_out) begin
            run_test("alu_random", 0, 3, 20);
        end
        if (!timed_out) begin
            run_test("load_store", 1, 3, 20);
        end
        if (!timed_out) begin
            run_test("branches", 2, 4, 20);
        end
        if (!timed_out) begin
            run_test("long_random", 3, 8, 31);
        end
        $display("tests run: %0d, tests failed: %0d, failed checks: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
